// ==== design/control_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module control_unit
  import ctrl_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        arst_n,
  input  wire logic        booted,
  // Opcode stream
  input  wire opcode_t     opcode,
  input  wire logic        opcode_valid,
  output logic             opcode_ready,
  // Wishbone classic slave for bootstrap
  input  wire logic        wb_cyc,
  input  wire logic        wb_stb,
  input  wire logic        wb_we,
  input  wire ucode_addr_t wb_adr,
  input  wire ucode_word_t wb_dat_w,
  output ucode_word_t      wb_dat_r,
  output logic             wb_ack,
  output logic             wb_err,
  // Control outputs to the datapath
  output reg_sel_t         reg_sel,
  output reg_src_t         reg_src,
  output alu_plane_t       alu_plane,
  output logic             reg_n_in,
  output logic             tmp0_n_in,
  output logic             tmp1_n_in,
  output logic             reg_n_out,
  output logic             tmp0_n_out,
  output logic             tmp1_n_out,
  output logic             mlu_n_out,
  output logic             shifter_n_out,
  output logic             control_valid,
  output logic             ucode_fault
);

  // Stage 1 to stage 2
  ucode_addr_t uop_addr;
  logic        uop_valid;
  // Look-ahead from the store back to the sequencer
  logic        last_uop;
  // Stage 2 to stage 3
  ucode_word_t uop_word;
  logic        word_valid;

  microop_sequencer u_sequencer (
    .clk          (clk),
    .arst_n       (arst_n),
    .booted       (booted),
    .opcode       (opcode),
    .opcode_valid (opcode_valid),
    .last_uop     (last_uop),
    .opcode_ready (opcode_ready),
    .uop_addr     (uop_addr),
    .uop_valid    (uop_valid)
  );

  microcode_store u_store (
    .clk        (clk),
    .arst_n     (arst_n),
    .uop_addr   (uop_addr),
    .uop_valid  (uop_valid),
    .booted     (booted),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .last_uop   (last_uop),
    .uop_word   (uop_word),
    .word_valid (word_valid),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .wb_err     (wb_err)
  );

  plane_decoder u_decoder (
    .clk           (clk),
    .arst_n        (arst_n),
    .uop_word      (uop_word),
    .word_valid    (word_valid),
    .reg_sel       (reg_sel),
    .reg_src       (reg_src),
    .alu_plane     (alu_plane),
    .reg_n_in      (reg_n_in),
    .tmp0_n_in     (tmp0_n_in),
    .tmp1_n_in     (tmp1_n_in),
    .reg_n_out     (reg_n_out),
    .tmp0_n_out    (tmp0_n_out),
    .tmp1_n_out    (tmp1_n_out),
    .mlu_n_out     (mlu_n_out),
    .shifter_n_out (shifter_n_out),
    .control_valid (control_valid),
    .ucode_fault   (ucode_fault)
  );

endmodule

`default_nettype wire

// ==== design/ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

  // Widths of the instruction and microcode formats
  localparam int opcode_w     = 6;
  localparam int uop_count_w  = 5;
  localparam int ucode_addr_w = opcode_w + uop_count_w;
  localparam int ucode_word_w = 32;
  localparam int plane_sel_w  = 3;
  localparam int alu_plane_w  = 4;
  localparam int reg_sel_w    = 2;
  localparam int reg_src_w    = 5;

  // Store holds one 32-entry slice per opcode
  localparam int ucode_depth = 1 << ucode_addr_w;

  typedef logic [opcode_w-1:0]     opcode_t;
  typedef logic [uop_count_w-1:0]  uop_count_t;
  typedef logic [ucode_addr_w-1:0] ucode_addr_t;
  typedef logic [ucode_word_w-1:0] ucode_word_t;
  typedef logic [plane_sel_w-1:0]  plane_sel_t;
  typedef logic [alu_plane_w-1:0]  alu_plane_t;
  typedef logic [reg_sel_w-1:0]    reg_sel_t;
  typedef logic [reg_src_w-1:0]    reg_src_t;

  // Final slot of an instruction even without the end bit
  localparam uop_count_t uop_count_last = '1;

  // Plane codes
  // In plane uses 0 to 3, anything above means no unit
  localparam plane_sel_t plane_none    = 3'd0;
  localparam plane_sel_t plane_reg     = 3'd1;
  localparam plane_sel_t plane_tmp0    = 3'd2;
  localparam plane_sel_t plane_tmp1    = 3'd3;
  // Out plane adds the two function units, 6 and 7 mean none
  localparam plane_sel_t plane_mlu     = 3'd4;
  localparam plane_sel_t plane_shifter = 3'd5;

  // Register selector values
  localparam reg_sel_t reg_sel_op0     = 2'd0;
  localparam reg_sel_t reg_sel_op1     = 2'd1;
  localparam reg_sel_t reg_sel_src     = 2'd2;
  localparam reg_sel_t reg_sel_illegal = 2'd3;

  // Microcode word layout, MSB first
  localparam int in_plane_hi     = 31;
  localparam int in_plane_lo     = 29;
  localparam int out_plane_hi    = 28;
  localparam int out_plane_lo    = 26;
  localparam int alu_plane_hi    = 25;
  localparam int alu_plane_lo    = 22;
  localparam int reg_sel_hi      = 21;
  localparam int reg_sel_lo      = 20;
  localparam int reg_src_hi      = 19;
  localparam int reg_src_lo      = 15;
  localparam int end_of_instr_bit = 14;
  // Bits 13 to 0 are reserved

  // Low two ALU bits for shifter direction and arithmetic mode
  localparam logic [1:0] alu_shift_left_arith = 2'b11;

  typedef enum logic {
    seq_idle,
    seq_run
  } seq_state_t;

endpackage

`default_nettype wire

// ==== design/microcode_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module microcode_store
  import ctrl_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        arst_n,
  input  wire ucode_addr_t uop_addr,
  input  wire logic        uop_valid,
  input  wire logic        booted,
  // Wishbone classic slave
  input  wire logic        wb_cyc,
  input  wire logic        wb_stb,
  input  wire logic        wb_we,
  input  wire ucode_addr_t wb_adr,
  input  wire ucode_word_t wb_dat_w,
  output logic             last_uop,
  output ucode_word_t      uop_word,
  output logic             word_valid,
  output ucode_word_t      wb_dat_r,
  output logic             wb_ack,
  output logic             wb_err
);

  // Microcode array
  ucode_word_t mem [ucode_depth];
  // Copy of the end bit per entry for the sequencer look-ahead
  logic        end_mem [ucode_depth];

  // Shared registered read port
  ucode_addr_t rd_addr;
  ucode_word_t rd_word;

  // New bus cycle, not yet answered
  logic bus_req;
  // Write is refused once the platform has booted
  logic bus_locked;
  logic wr_en;

  // Ack or err is high for exactly one cycle
  // The master drops stb after that cycle so no second response
  assign bus_req    = wb_cyc && wb_stb && !wb_ack && !wb_err;
  assign bus_locked = wb_we && booted;
  assign wr_en      = bus_req && wb_we && !booted;

  // Pipeline owns the port while a slot is live
  // Bus reads are only issued when the pipeline is idle
  assign rd_addr = uop_valid ? uop_addr : wb_adr;

  // Look-ahead end bit for the address stage 1 is issuing
  assign last_uop = end_mem[uop_addr];

  // Array and shadow are written together
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wb_adr]     <= wb_dat_w;
      end_mem[wb_adr] <= wb_dat_w[end_of_instr_bit];
    end
  end

  // Read data lands one cycle after the address
  always_ff @(posedge clk) begin
    rd_word <= mem[rd_addr];
  end

  // Same register feeds stage 3 and the bus
  assign uop_word = rd_word;
  assign wb_dat_r = rd_word;

  // Slot valid follows the address by one cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      word_valid <= 1'b0;
    end else begin
      word_valid <= uop_valid;
    end
  end

  // Bus response
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack <= 1'b0;
      wb_err <= 1'b0;
    end else begin
      // Reads and boot-time writes complete normally
      wb_ack <= bus_req && !bus_locked;
      // Late write leaves the array untouched
      wb_err <= bus_req && bus_locked;
    end
  end

endmodule

`default_nettype wire

// ==== design/microop_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module microop_sequencer
  import ctrl_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    arst_n,
  input  wire logic    booted,
  input  wire opcode_t opcode,
  input  wire logic    opcode_valid,
  input  wire logic    last_uop,
  output logic         opcode_ready,
  output ucode_addr_t  uop_addr,
  output logic         uop_valid
);

  seq_state_t state;
  opcode_t    cur_opcode;
  uop_count_t count;

  // Micro-op currently on uop_addr closes the instruction
  logic issue_last;
  // Handshake completes on this edge
  logic accept;

  // End bit comes from the store shadow at the issued address
  // so the decision is made before the word leaves stage 2
  // Count 31 is the hard stop for a word missing its end bit
  assign issue_last = (state == seq_run) && (last_uop || (count == uop_count_last));

  // Take a new opcode when idle or while the last micro-op goes out
  // Nothing is taken before the store has been loaded
  assign opcode_ready = booted && ((state == seq_idle) || issue_last);

  assign accept = opcode_valid && opcode_ready;

  // Store address is opcode in the high bits and micro-op index below
  assign uop_addr = {cur_opcode, count};

  // A slot is live whenever the machine is running
  // Idle cycles go down the pipe as bubbles
  assign uop_valid = (state == seq_run);

  // State and counter
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= seq_idle;
      count <= '0;
    end else begin
      if (accept) begin
        // New instruction starts at micro-op 0
        // Also covers back to back intake on the last micro-op
        state <= seq_run;
        count <= '0;
      end else if (issue_last) begin
        // Nothing waiting so drop to idle
        state <= seq_idle;
        count <= '0;
      end else if (state == seq_run) begin
        // One micro-op per cycle
        count <= count + 1'b1;
      end
    end
  end

  // Opcode of the running instruction
  always_ff @(posedge clk) begin
    if (accept) begin
      cur_opcode <= opcode;
    end
  end

endmodule

`default_nettype wire

// ==== design/plane_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module plane_decoder
  import ctrl_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        arst_n,
  input  wire ucode_word_t uop_word,
  input  wire logic        word_valid,
  output reg_sel_t         reg_sel,
  output reg_src_t         reg_src,
  output alu_plane_t       alu_plane,
  // In plane strobes, active low
  output logic             reg_n_in,
  output logic             tmp0_n_in,
  output logic             tmp1_n_in,
  // Out plane strobes, active low
  output logic             reg_n_out,
  output logic             tmp0_n_out,
  output logic             tmp1_n_out,
  output logic             mlu_n_out,
  output logic             shifter_n_out,
  output logic             control_valid,
  output logic             ucode_fault
);

  // Fields of the incoming word
  plane_sel_t in_plane;
  plane_sel_t out_plane;
  alu_plane_t alu_field;
  reg_sel_t   sel_field;
  reg_src_t   src_field;

  logic illegal;
  // Plane codes after suppression
  plane_sel_t in_eff;
  plane_sel_t out_eff;
  // Inverting one-hot decodes
  logic [7:0] in_dec_n;
  logic [7:0] out_dec_n;

  // Behaves like a 74138 with all enables active
  function automatic logic [7:0] decode_n(input plane_sel_t code);
    logic [7:0] onehot;
    onehot = 8'b1 << code;
    return ~onehot;
  endfunction

  assign in_plane  = uop_word[in_plane_hi:in_plane_lo];
  assign out_plane = uop_word[out_plane_hi:out_plane_lo];
  assign alu_field = uop_word[alu_plane_hi:alu_plane_lo];
  assign sel_field = uop_word[reg_sel_hi:reg_sel_lo];
  assign src_field = uop_word[reg_src_hi:reg_src_lo];

  // Legality check
  always_comb begin
    illegal = 1'b0;
    // Selector value 3 has no register behind it
    if (sel_field == reg_sel_illegal) begin
      illegal = 1'b1;
    end
    // One unit cannot load and drive the bus in the same micro-op
    // Only REG and the two TMPs sit on both planes
    if ((in_plane == out_plane) && (in_plane >= plane_reg) && (in_plane <= plane_tmp1)) begin
      illegal = 1'b1;
    end
    // Shifter has no left arithmetic mode
    if ((out_plane == plane_shifter) && (alu_field[1:0] == alu_shift_left_arith)) begin
      illegal = 1'b1;
    end
  end

  // Bubbles and illegal words select no unit
  assign in_eff  = (word_valid && !illegal) ? in_plane  : plane_none;
  assign out_eff = (word_valid && !illegal) ? out_plane : plane_none;

  assign in_dec_n  = decode_n(in_eff);
  assign out_dec_n = decode_n(out_eff);

  // Strobes, valid and fault
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reg_n_in      <= 1'b1;
      tmp0_n_in     <= 1'b1;
      tmp1_n_in     <= 1'b1;
      reg_n_out     <= 1'b1;
      tmp0_n_out    <= 1'b1;
      tmp1_n_out    <= 1'b1;
      mlu_n_out     <= 1'b1;
      shifter_n_out <= 1'b1;
      control_valid <= 1'b0;
      ucode_fault   <= 1'b0;
    end else begin
      reg_n_in      <= in_dec_n[plane_reg];
      tmp0_n_in     <= in_dec_n[plane_tmp0];
      tmp1_n_in     <= in_dec_n[plane_tmp1];
      reg_n_out     <= out_dec_n[plane_reg];
      tmp0_n_out    <= out_dec_n[plane_tmp0];
      tmp1_n_out    <= out_dec_n[plane_tmp1];
      mlu_n_out     <= out_dec_n[plane_mlu];
      shifter_n_out <= out_dec_n[plane_shifter];
      // Illegal words still take their slot
      control_valid <= word_valid;
      // Sticky until reset
      ucode_fault   <= ucode_fault || (word_valid && illegal);
    end
  end

  // Plain fields go out with the strobes
  always_ff @(posedge clk) begin
    reg_sel   <= sel_field;
    reg_src   <= src_field;
    alu_plane <= alu_field;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/ctrl_pkg.sv
design/microop_sequencer.sv
design/microcode_store.sv
design/plane_decoder.sv
design/control_unit.sv
sim/control_unit_properties.sv
sim/control_checker.sv
sim/tb_control_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the control unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_control_unit \
  -f filelist.f \
  -o sim_control_unit

./obj_dir/sim_control_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
  exit 1
fi
if ! grep -q "No errors" sim.log; then
  exit 1
fi
exit 0

// ==== sim/control_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module control_checker
  import ctrl_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        arst_n,
  input  wire opcode_t     opcode,
  input  wire logic        opcode_valid,
  input  wire logic        opcode_ready,
  input  wire logic        wb_cyc,
  input  wire logic        wb_stb,
  input  wire logic        wb_we,
  input  wire ucode_addr_t wb_adr,
  input  wire ucode_word_t wb_dat_w,
  input  wire logic        wb_ack,
  input  wire reg_sel_t    reg_sel,
  input  wire reg_src_t    reg_src,
  input  wire alu_plane_t  alu_plane,
  input  wire logic        reg_n_in,
  input  wire logic        tmp0_n_in,
  input  wire logic        tmp1_n_in,
  input  wire logic        reg_n_out,
  input  wire logic        tmp0_n_out,
  input  wire logic        tmp1_n_out,
  input  wire logic        mlu_n_out,
  input  wire logic        shifter_n_out,
  input  wire logic        control_valid,
  input  wire logic        ucode_fault,
  output int               error_count,
  output int               check_count,
  output int               valid_count,
  output int               pending,
  output int               illegal_count,
  output int               fault_errors
);

  // Image as seen on the bus, only acknowledged writes land here
  ucode_word_t model_mem [ucode_depth];
  // Words still owed by the pipeline, oldest first
  ucode_word_t exp_q [$];
  logic        fault_exp;
  ucode_word_t word;
  logic [19:0] exp_ctl;
  logic [7:0]  act_strb;
  logic        done;

  // Expected {illegal, strobes, alu, reg_sel, reg_src} for one word
  // Strobe order from bit 7 is reg/tmp0/tmp1 in, then reg/tmp0/tmp1/mlu/shifter out
  function automatic logic [19:0] expected_controls(input ucode_word_t w);
    plane_sel_t in_p;
    plane_sel_t out_p;
    alu_plane_t alu;
    reg_sel_t   sel;
    reg_src_t   src;
    logic [7:0] strb;
    logic       bad;
    in_p  = w[31:29];
    out_p = w[28:26];
    alu   = w[25:22];
    sel   = w[21:20];
    src   = w[19:15];
    strb  = 8'hff;
    case (in_p)
      3'd1: strb[7] = 1'b0;
      3'd2: strb[6] = 1'b0;
      3'd3: strb[5] = 1'b0;
      default: strb = strb;
    endcase
    case (out_p)
      3'd1: strb[4] = 1'b0;
      3'd2: strb[3] = 1'b0;
      3'd3: strb[2] = 1'b0;
      3'd4: strb[1] = 1'b0;
      3'd5: strb[0] = 1'b0;
      default: strb = strb;
    endcase
    bad = (sel == 2'd3) || ((in_p == out_p) && (in_p >= 3'd1) && (in_p <= 3'd3))
          || ((out_p == 3'd5) && (alu[1:0] == 2'b11));
    // Illegal words keep every unit off the bus
    if (bad) begin
      strb = 8'hff;
    end
    return {bad, strb, alu, sel, src};
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    error_count++;
    $display("mismatch at %0t: %s expected %h got %h", $time, name, exp_v, act_v);
  endtask

  task automatic compare_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    check_count++;
    if (act_v !== exp_v) begin
      report_mismatch(name, exp_v, act_v);
    end
  endtask

  initial begin
    error_count   = 0;
    check_count   = 0;
    valid_count   = 0;
    pending       = 0;
    illegal_count = 0;
    fault_errors  = 0;
    fault_exp     = 1'b0;
  end

  // Inputs change on the rising edge, so everything is stable here
  always @(negedge clk) begin
    if (!arst_n) begin
      exp_q.delete();
      fault_exp = 1'b0;
    end else begin
      if (wb_cyc && wb_stb && wb_we && wb_ack) begin
        model_mem[wb_adr] = wb_dat_w;
      end
      // Handshake completes on the next rising edge
      if (opcode_valid && opcode_ready) begin
        done = 1'b0;
        for (int c = 0; c < 32; c++) begin
          if (!done) begin
            word = model_mem[{opcode, c[4:0]}];
            exp_q.push_back(word);
            done = word[end_of_instr_bit];
          end
        end
      end
      if (control_valid) begin
        valid_count++;
        if (exp_q.size() == 0) begin
          error_count++;
          $display("control_valid at %0t with no micro-op expected", $time);
        end else begin
          word     = exp_q.pop_front();
          exp_ctl  = expected_controls(word);
          act_strb = {reg_n_in, tmp0_n_in, tmp1_n_in, reg_n_out, tmp0_n_out,
                      tmp1_n_out, mlu_n_out, shifter_n_out};
          if (exp_ctl[19]) begin
            illegal_count++;
            fault_exp = 1'b1;
          end
          compare_value("strobes", {24'd0, exp_ctl[18:11]}, {24'd0, act_strb});
          compare_value("alu_plane", {28'd0, exp_ctl[10:7]}, {28'd0, alu_plane});
          compare_value("reg_sel", {30'd0, exp_ctl[6:5]}, {30'd0, reg_sel});
          compare_value("reg_src", {27'd0, exp_ctl[4:0]}, {27'd0, reg_src});
        end
      end
      // Sticky fault follows the first illegal word
      check_count++;
      if (ucode_fault !== fault_exp) begin
        fault_errors++;
        report_mismatch("ucode_fault", {31'd0, fault_exp}, {31'd0, ucode_fault});
      end
      pending = exp_q.size();
    end
  end

endmodule

`default_nettype wire

// ==== sim/control_unit_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module control_unit_properties
  import ctrl_pkg::*;
(
  input wire logic clk,
  input wire logic arst_n,
  input wire logic control_valid,
  input wire logic reg_n_in,
  input wire logic tmp0_n_in,
  input wire logic tmp1_n_in,
  input wire logic reg_n_out,
  input wire logic tmp0_n_out,
  input wire logic tmp1_n_out,
  input wire logic mlu_n_out,
  input wire logic shifter_n_out,
  input wire logic wb_ack,
  input wire logic wb_err
);

  logic all_high;

  assign all_high = reg_n_in && tmp0_n_in && tmp1_n_in && reg_n_out && tmp0_n_out
                    && tmp1_n_out && mlu_n_out && shifter_n_out;

  // A unit never loads and drives the bus in one micro-op
  a_reg_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
    !(!reg_n_in && !reg_n_out))
    else $error("REG in and out strobes both low");
  a_tmp0_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
    !(!tmp0_n_in && !tmp0_n_out))
    else $error("TMP0 in and out strobes both low");
  a_tmp1_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
    !(!tmp1_n_in && !tmp1_n_out))
    else $error("TMP1 in and out strobes both low");

  // Bubbles select nothing
  a_idle_strobes: assert property (@(posedge clk) disable iff (!arst_n)
    !control_valid |-> all_high)
    else $error("strobe low without control_valid");

  // One response kind per bus cycle
  a_bus_response: assert property (@(posedge clk) disable iff (!arst_n)
    !(wb_ack && wb_err))
    else $error("wb_ack and wb_err high together");

endmodule

bind control_unit control_unit_properties u_properties (
  .clk           (clk),
  .arst_n        (arst_n),
  .control_valid (control_valid),
  .reg_n_in      (reg_n_in),
  .tmp0_n_in     (tmp0_n_in),
  .tmp1_n_in     (tmp1_n_in),
  .reg_n_out     (reg_n_out),
  .tmp0_n_out    (tmp0_n_out),
  .tmp1_n_out    (tmp1_n_out),
  .mlu_n_out     (mlu_n_out),
  .shifter_n_out (shifter_n_out),
  .wb_ack        (wb_ack),
  .wb_err        (wb_err)
);

`default_nettype wire

// ==== sim/tb_control_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_control_unit
  import ctrl_pkg::*;
();

  localparam int n_images  = 8;
  localparam int max_words = 6;
  localparam int n_stream  = 40;
  localparam int n_b2b     = 8;
  localparam int timeout_limit = (n_stream + n_b2b) * max_words * 2 + 2048 + 1000;

  logic        clk;
  logic        arst_n;
  logic        booted;
  opcode_t     opcode;
  logic        opcode_valid;
  logic        opcode_ready;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  ucode_addr_t wb_adr;
  ucode_word_t wb_dat_w;
  ucode_word_t wb_dat_r;
  logic        wb_ack;
  logic        wb_err;
  reg_sel_t    reg_sel;
  reg_src_t    reg_src;
  alu_plane_t  alu_plane;
  logic        reg_n_in;
  logic        tmp0_n_in;
  logic        tmp1_n_in;
  logic        reg_n_out;
  logic        tmp0_n_out;
  logic        tmp1_n_out;
  logic        mlu_n_out;
  logic        shifter_n_out;
  logic        control_valid;
  logic        ucode_fault;

  int error_count;
  int check_count;
  int valid_count;
  int pending;
  int illegal_count;
  int fault_errors;

  // Microcode image written at boot
  opcode_t     img_op [n_images];
  int          img_len [n_images];
  ucode_word_t img_word [n_images][max_words];

  int   tb_fails;
  int   tb_checks;
  int   cycle_count;
  int   mark;
  // Gap watch for the back to back phase
  logic b2b_watch;
  logic b2b_started;
  int   b2b_gaps;
  int   b2b_base;
  int   b2b_total;

  control_unit DUT (.*);

  control_checker u_checker (.*);

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_limit) begin
      $display("timeout: run stopped after %0d cycles", cycle_count);
      $display("Errors found");
      $finish;
    end
  end

  always @(negedge clk) begin
    if (b2b_watch) begin
      if (control_valid) begin
        b2b_started = 1'b1;
      end else if (b2b_started && (valid_count - b2b_base) < b2b_total) begin
        b2b_gaps++;
      end
    end
  end

  function automatic int failures_now();
    return tb_fails + error_count;
  endfunction

  task automatic fail_note(input string msg);
    tb_fails++;
    $display("%0t: %s", $time, msg);
  endtask

  task automatic expect_value(input string name, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
    tb_checks++;
    if (act_v !== exp_v) begin
      tb_fails++;
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp_v, act_v);
    end
  endtask

  task automatic print_result(input int num, input string name, input int fails);
    $display("test %0d %s: %s (failures=%0d)", num, name, (fails == 0) ? "pass" : "FAIL",
             fails);
  endtask

  // Random word that is legal unless bad is set
  function automatic ucode_word_t make_word(input logic last, input logic bad);
    ucode_word_t w;
    plane_sel_t  in_p;
    plane_sel_t  out_p;
    alu_plane_t  alu;
    reg_sel_t    sel;
    w     = $urandom;
    in_p  = 3'($urandom % 8);
    out_p = 3'($urandom % 8);
    alu   = 4'($urandom % 16);
    sel   = 2'($urandom % 3);
    if ((in_p == out_p) && (in_p >= 3'd1) && (in_p <= 3'd3)) begin
      out_p = 3'd4;
    end
    if ((out_p == 3'd5) && (alu[1:0] == 2'b11)) begin
      alu[1:0] = 2'b00;
    end
    if (bad) begin
      case ($urandom % 3)
        0: sel = 2'd3;
        1: begin
          // Any of REG, TMP0 or TMP1 on both planes
          in_p  = 3'(1 + ($urandom % 3));
          out_p = in_p;
        end
        default: begin
          out_p    = 3'd5;
          alu[1:0] = 2'b11;
        end
      endcase
    end
    w[31:29] = in_p;
    w[28:26] = out_p;
    w[25:22] = alu;
    w[21:20] = sel;
    w[14]    = last;
    return w;
  endfunction

  // Called just after a rising edge and returns just after one
  task automatic wb_access(input logic we, input ucode_addr_t adr, input ucode_word_t dat,
                           output ucode_word_t rdata, output int acks, output int errs);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    acks = 0;
    errs = 0;
    @(negedge clk);
    while (!wb_ack && !wb_err) begin
      @(negedge clk);
    end
    acks  += int'(wb_ack);
    errs  += int'(wb_err);
    rdata = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    // A second response here would be a protocol error
    @(negedge clk);
    acks += int'(wb_ack);
    errs += int'(wb_err);
    @(posedge clk);
  endtask

  // Leaves opcode_valid high for the caller to drop before a gap
  task automatic send_opcode(input opcode_t op);
    opcode       <= op;
    opcode_valid <= 1'b1;
    @(negedge clk);
    while (!opcode_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic wait_drain();
    @(negedge clk);
    while (pending != 0) begin
      @(negedge clk);
    end
    repeat (4) @(posedge clk);
  endtask

  task automatic check_reset_state();
    expect_value("strobes", 32'hff, {24'd0, reg_n_in, tmp0_n_in, tmp1_n_in, reg_n_out,
                 tmp0_n_out, tmp1_n_out, mlu_n_out, shifter_n_out});
    expect_value("opcode_ready", 32'd0, {31'd0, opcode_ready});
    expect_value("control_valid", 32'd0, {31'd0, control_valid});
  endtask

  initial begin
    ucode_word_t rdata;
    ucode_word_t old_word;
    ucode_addr_t adr;
    int          acks;
    int          errs;
    int          idx;
    int          gap;
    int          exp_total;
    int          base;
    logic        dup;
    rdata = $urandom(32'h6d8aeff6);
    clk = 1'b0;
    arst_n = 1'b0;
    booted = 1'b0;
    opcode = '0;
    opcode_valid = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    tb_fails = 0;
    tb_checks = 0;
    cycle_count = 0;
    b2b_watch = 1'b0;
    b2b_started = 1'b0;
    b2b_gaps = 0;

    // Test 6 reset state
    mark = failures_now();
    repeat (5) begin
      @(negedge clk);
      check_reset_state();
    end
    @(posedge clk);
    arst_n <= 1'b1;
    repeat (2) begin
      @(negedge clk);
      check_reset_state();
    end
    @(posedge clk);
    print_result(6, "reset state", failures_now() - mark);

    // Eight distinct opcodes with word 0 of image 2 always illegal
    for (int i = 0; i < n_images; i++) begin
      do begin
        img_op[i] = 6'($urandom % 64);
        dup = 1'b0;
        for (int k = 0; k < i; k++) begin
          dup = dup || (img_op[k] == img_op[i]);
        end
      end while (dup);
      img_len[i] = 1 + ($urandom % max_words);
      for (int j = 0; j < img_len[i]; j++) begin
        img_word[i][j] = make_word(j == img_len[i] - 1,
                                   (($urandom % 8) == 0) || (i == 2 && j == 0));
      end
    end

    // Test 1 bootstrap and readback
    mark = failures_now();
    for (int i = 0; i < n_images; i++) begin
      for (int j = 0; j < img_len[i]; j++) begin
        adr = {img_op[i], 5'(j)};
        wb_access(1'b1, adr, img_word[i][j], rdata, acks, errs);
        if (acks != 1 || errs != 0) begin
          fail_note($sformatf("write to %h did not get exactly one ack", adr));
        end
      end
    end
    for (int i = 0; i < n_images; i++) begin
      for (int j = 0; j < img_len[i]; j++) begin
        adr = {img_op[i], 5'(j)};
        wb_access(1'b0, adr, '0, rdata, acks, errs);
        if (acks != 1 || errs != 0) begin
          fail_note($sformatf("read of %h did not get exactly one ack", adr));
        end
        expect_value("wb_dat_r", img_word[i][j], rdata);
      end
    end
    print_result(1, "bootstrap readback", failures_now() - mark);

    // Test 2 boot lock
    mark = failures_now();
    booted <= 1'b1;
    @(posedge clk);
    adr = {img_op[0], 5'd0};
    old_word = img_word[0][0];
    wb_access(1'b1, adr, ~old_word, rdata, acks, errs);
    if (errs != 1 || acks != 0) begin
      fail_note("write after boot was not refused with a single wb_err");
    end
    wb_access(1'b0, adr, '0, rdata, acks, errs);
    if (acks != 1 || errs != 0) begin
      fail_note("read after boot did not get exactly one ack");
    end
    expect_value("wb_dat_r", old_word, rdata);
    print_result(2, "boot lock", failures_now() - mark);

    // Test 3 random stream with gaps
    mark = failures_now();
    base = valid_count;
    exp_total = 0;
    for (int n = 0; n < n_stream; n++) begin
      idx = $urandom % n_images;
      send_opcode(img_op[idx]);
      exp_total += img_len[idx];
      gap = $urandom % 4;
      if (gap != 0) begin
        opcode_valid <= 1'b0;
        repeat (gap) @(posedge clk);
      end
    end
    opcode_valid <= 1'b0;
    wait_drain();
    expect_value("control_valid count", exp_total, valid_count - base);
    print_result(3, "micro-op sequence", failures_now() - mark);

    // Test 4 back to back intake
    mark = failures_now();
    b2b_base = valid_count;
    b2b_total = 0;
    b2b_watch = 1'b1;
    for (int n = 0; n < n_b2b; n++) begin
      idx = $urandom % n_images;
      b2b_total += img_len[idx];
      send_opcode(img_op[idx]);
    end
    opcode_valid <= 1'b0;
    wait_drain();
    b2b_watch = 1'b0;
    expect_value("control_valid count", b2b_total, valid_count - b2b_base);
    if (b2b_gaps != 0) begin
      fail_note($sformatf("%0d invalid slots between back to back instructions", b2b_gaps));
    end
    print_result(4, "back to back intake", failures_now() - mark);

    // Test 5 illegal words
    mark = tb_fails + fault_errors;
    if (illegal_count == 0) begin
      fail_note("no illegal word reached the decoder");
    end
    expect_value("ucode_fault", 32'd1, {31'd0, ucode_fault});
    print_result(5, "illegal words", tb_fails + fault_errors - mark);

    $display("checks=%0d failures=%0d", tb_checks + check_count, failures_now());
    if (failures_now() == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
